/* verilog/lsu_settings.svh */
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// MIPS major opcodes for loads.
`define EXE_LB  6'h20
`define EXE_LH  6'h21
`define EXE_LW  6'h23
`define EXE_LBU 6'h24
`define EXE_LHU 6'h25

// MIPS major opcodes for stores.
`define EXE_SB  6'h28
`define EXE_SH  6'h29
`define EXE_SW  6'h2B

// Data RAM geometry, in 32-bit words.
`define RAM_ADDR_BITS 8
`define RAM_WORDS     (1 << `RAM_ADDR_BITS)

`endif

/* verilog/lsu_pkg.sv */
`include "lsu_settings.svh"

package lsu_pkg;

   typedef logic [31:0] word_t;                    // Data or byte address.
   typedef logic [5:0]  opcode_t;                  // Major opcode field.
   typedef logic [3:0]  byte_sel_t;                // Bit n enables byte n.
   typedef logic [`RAM_ADDR_BITS-1:0] ram_index_t; // Word index into the RAM.

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_BUS,
      ST_FINISH
   } bus_state_t;

endpackage

/* verilog/mem_control.sv */
`timescale 1ns/1ns
`include "lsu_settings.svh"

module mem_control
   import lsu_pkg::*;
(
   input  opcode_t   op_code,
   input  word_t     addr,
   input  word_t     read_data,
   input  word_t     write_data,
   output logic      mem_en,
   output logic      is_store,
   output byte_sel_t memsel,
   output word_t     final_wdata,
   output word_t     final_rdata,
   output logic      addr_error_lw,
   output logic      addr_error_sw
);

   logic [15:0] rd_half;
   logic [7:0]  rd_byte;

   // Lane extraction for sub-word loads.
   assign rd_half = addr[1] ? read_data[31:16] : read_data[15:0];
   assign rd_byte = read_data[8*addr[1:0] +: 8];

   always_comb begin
      mem_en        = 1'b0;
      is_store      = 1'b0;
      memsel        = 4'b0000;
      final_wdata   = '0;
      final_rdata   = '0;
      addr_error_lw = 1'b0;
      addr_error_sw = 1'b0;
      case (op_code)
         `EXE_SW: begin
            is_store = 1'b1;
            if (addr[1:0] == 2'b00) begin
               mem_en      = 1'b1;
               memsel      = 4'b1111;
               final_wdata = write_data;
            end else begin
               addr_error_sw = 1'b1;
            end
         end
         `EXE_SH: begin
            is_store    = 1'b1;
            final_wdata = {2{write_data[15:0]}}; // Same half in both lanes.
            if (!addr[0]) begin
               mem_en = 1'b1;
               memsel = addr[1] ? 4'b1100 : 4'b0011;
            end else begin
               addr_error_sw = 1'b1;
            end
         end
         `EXE_SB: begin
            is_store    = 1'b1;
            mem_en      = 1'b1;
            final_wdata = {4{write_data[7:0]}};
            memsel      = 4'b0001 << addr[1:0];  // One lane, never misaligned.
         end
         `EXE_LW: begin
            if (addr[1:0] == 2'b00) begin
               mem_en      = 1'b1;
               memsel      = 4'b1111;
               final_rdata = read_data;
            end else begin
               addr_error_lw = 1'b1;
            end
         end
         `EXE_LH: begin
            if (!addr[0]) begin
               mem_en      = 1'b1;
               memsel      = 4'b1111;
               final_rdata = {{16{rd_half[15]}}, rd_half};
            end else begin
               addr_error_lw = 1'b1;
            end
         end
         `EXE_LHU: begin
            if (!addr[0]) begin
               mem_en      = 1'b1;
               memsel      = 4'b1111;
               final_rdata = {16'b0, rd_half};
            end else begin
               addr_error_lw = 1'b1;
            end
         end
         `EXE_LB: begin
            mem_en      = 1'b1;
            memsel      = 4'b1111;
            final_rdata = {{24{rd_byte[7]}}, rd_byte};
         end
         `EXE_LBU: begin
            mem_en      = 1'b1;
            memsel      = 4'b1111;
            final_rdata = {24'b0, rd_byte};
         end
         default: begin
            // Unknown opcode, nothing to do on the bus.
            mem_en = 1'b0;
         end
      endcase
   end

endmodule

/* verilog/lsu_bus_master.sv */
`timescale 1ns/1ns

module lsu_bus_master
   import lsu_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      start,
   input  opcode_t   op_code,
   input  word_t     addr,
   input  word_t     write_data,
   output logic      busy,
   output logic      done,
   output word_t     read_data,
   output logic      addr_error_lw,
   output logic      addr_error_sw,
   output opcode_t   req_op,
   output word_t     req_addr,
   output word_t     req_wdata,
   input  logic      mc_mem_en,
   input  logic      mc_is_store,
   input  byte_sel_t mc_sel,
   input  word_t     mc_wdata,
   input  word_t     mc_rdata,
   input  logic      mc_err_lw,
   input  logic      mc_err_sw,
   output logic      wb_cyc,
   output logic      wb_stb,
   output logic      wb_we,
   output word_t     wb_adr,
   output byte_sel_t wb_sel,
   output word_t     wb_dat_w,
   input  logic      wb_ack
);

   bus_state_t state;
   logic       bus_req;

   assign busy = (state != ST_IDLE);
   assign done = (state == ST_FINISH); // One cycle, FINISH always returns to IDLE.

   // Classic cycle, cyc and stb move together.
   assign wb_cyc   = bus_req;
   assign wb_stb   = bus_req;
   assign wb_adr   = req_addr;
   assign wb_sel   = mc_sel;
   assign wb_dat_w = mc_wdata;

   // Request payload, held for mem_control while busy.
   always_ff @(posedge clk) begin
      if (state == ST_IDLE && start) begin
         req_op    <= op_code;
         req_addr  <= addr;
         req_wdata <= write_data;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state         <= ST_IDLE;
         bus_req       <= 1'b0;
         wb_we         <= 1'b0;
         read_data     <= '0;
         addr_error_lw <= 1'b0;
         addr_error_sw <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (start)
                  state <= ST_BUS;
            end
            ST_BUS: begin
               if (!bus_req) begin
                  if (mc_mem_en) begin
                     bus_req <= 1'b1;           // Open the bus cycle.
                     wb_we   <= mc_is_store;
                  end else begin
                     state         <= ST_FINISH; // Error or unknown op, no bus.
                     read_data     <= '0;
                     addr_error_lw <= mc_err_lw;
                     addr_error_sw <= mc_err_sw;
                  end
               end else if (wb_ack) begin
                  bus_req       <= 1'b0;
                  wb_we         <= 1'b0;
                  state         <= ST_FINISH;
                  read_data     <= mc_is_store ? '0 : mc_rdata;
                  addr_error_lw <= 1'b0;
                  addr_error_sw <= 1'b0;
               end
            end
            ST_FINISH: state <= ST_IDLE;
            default:   state <= ST_IDLE;
         endcase
      end
   end

endmodule

/* verilog/data_ram.sv */
`timescale 1ns/1ns
`include "lsu_settings.svh"

module data_ram
   import lsu_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      wb_cyc,
   input  logic      wb_stb,
   input  logic      wb_we,
   input  word_t     wb_adr,
   input  byte_sel_t wb_sel,
   input  word_t     wb_dat_w,
   output word_t     wb_dat_r,
   output logic      wb_ack
);

   word_t      mem [0:`RAM_WORDS-1];
   ram_index_t idx;
   logic       access;

   assign idx    = wb_adr[`RAM_ADDR_BITS+1:2]; // Upper bits ignored, memory wraps.
   assign access = wb_cyc && wb_stb && !wb_ack;

   initial begin
      for (int i = 0; i < `RAM_WORDS; i++)
         mem[i] = '0;
   end

   always @(posedge clk) begin
      if (access) begin
         if (wb_we) begin
            for (int b = 0; b < 4; b++) begin
               if (wb_sel[b])
                  mem[idx][8*b +: 8] <= wb_dat_w[8*b +: 8];
            end
         end
         wb_dat_r <= mem[idx];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         wb_ack <= 1'b0;
      else
         wb_ack <= access; // Single-cycle ack per strobe.
   end

endmodule

/* verilog/mem_stage.sv */
`timescale 1ns/1ns

module mem_stage
   import lsu_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    start,
   input  opcode_t op_code,
   input  word_t   addr,
   input  word_t   write_data,
   output logic    busy,
   output logic    done,
   output word_t   read_data,
   output logic    addr_error_lw,
   output logic    addr_error_sw
);

   opcode_t   req_op;
   word_t     req_addr;
   word_t     req_wdata;
   logic      mc_mem_en;
   logic      mc_is_store;
   byte_sel_t mc_sel;
   word_t     mc_wdata;
   word_t     mc_rdata;
   logic      mc_err_lw;
   logic      mc_err_sw;
   logic      wb_cyc;
   logic      wb_stb;
   logic      wb_we;
   word_t     wb_adr;
   byte_sel_t wb_sel;
   word_t     wb_dat_w;
   word_t     wb_dat_r;
   logic      wb_ack;

   lsu_bus_master master0 (
      .clk, .rst_n, .start, .op_code, .addr, .write_data,
      .busy, .done, .read_data, .addr_error_lw, .addr_error_sw,
      .req_op, .req_addr, .req_wdata,
      .mc_mem_en, .mc_is_store, .mc_sel, .mc_wdata, .mc_rdata,
      .mc_err_lw, .mc_err_sw,
      .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_dat_w, .wb_ack
   );

   mem_control align0 (
      .op_code       (req_op),
      .addr          (req_addr),
      .read_data     (wb_dat_r),    // RAM word straight into the extractor.
      .write_data    (req_wdata),
      .mem_en        (mc_mem_en),
      .is_store      (mc_is_store),
      .memsel        (mc_sel),
      .final_wdata   (mc_wdata),
      .final_rdata   (mc_rdata),
      .addr_error_lw (mc_err_lw),
      .addr_error_sw (mc_err_sw)
   );

   data_ram ram0 (
      .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel,
      .wb_dat_w, .wb_dat_r, .wb_ack
   );

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period.
   end

   initial begin
      rst_n = 1'b0;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

/* testbench/mem_stage_props.sv */
`timescale 1ns/1ns

module mem_stage_props
   import lsu_pkg::*;
(
   input logic      clk,
   input logic      rst_n,
   input logic      done,
   input logic      wb_cyc,
   input logic      wb_stb,
   input logic      wb_we,
   input word_t     wb_adr,
   input byte_sel_t wb_sel,
   input word_t     wb_dat_w,
   input logic      wb_ack,
   input logic      mc_err_lw,
   input logic      mc_err_sw
);

   int assert_failures = 0;

   // A waiting strobe keeps its cycle and its request fields.
   stb_holds_request: assert property (@(posedge clk) disable iff (!rst_n)
                                       wb_stb && !wb_ack |=> wb_cyc && $stable(wb_we) &&
                                       $stable(wb_adr) && $stable(wb_sel) &&
                                       $stable(wb_dat_w))
      else begin
         assert_failures++;
         $error("wb_cyc or the request fields changed before wb_ack");
      end

   stb_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
                                   wb_stb && !wb_ack |=> wb_stb)
      else begin
         assert_failures++;
         $error("wb_stb dropped before wb_ack");
      end

   done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
      else begin
         assert_failures++;
         $error("done held for more than one cycle");
      end

   // An alignment error must finish without opening a bus cycle.
   no_bus_on_error: assert property (@(posedge clk) disable iff (!rst_n)
                                     $rose(wb_cyc) |-> !(mc_err_lw || mc_err_sw))
      else begin
         assert_failures++;
         $error("bus cycle started for a misaligned access");
      end

endmodule

/* testbench/mem_stage_tb.sv */
`timescale 1ns/1ns
`include "lsu_settings.svh"

module mem_stage_tb
   import lsu_pkg::*;
();

   logic        clk, rst_n, start, busy, done, addr_error_lw, addr_error_sw;
   opcode_t     op_code;
   word_t       addr, write_data, read_data;
   logic [15:0] lfsr = 16'd9;
   logic [7:0]  model [0:1023];   // Byte image of the RAM that wraps like it.
   int          checks = 0;
   int          errors = 0;
   int          test_checks = 0;
   int          test_errors = 0;
   opcode_t     op_table [0:7] = '{`EXE_LB, `EXE_LH, `EXE_LW, `EXE_LBU,
                                   `EXE_LHU, `EXE_SB, `EXE_SH, `EXE_SW};

   tb_clock clk0 (.clk, .rst_n);

   mem_stage dut0 (
      .clk, .rst_n, .start, .op_code, .addr, .write_data,
      .busy, .done, .read_data, .addr_error_lw, .addr_error_sw
   );

   bind lsu_bus_master mem_stage_props props0 (
      .clk, .rst_n, .done, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_dat_w,
      .wb_ack, .mc_err_lw, .mc_err_sw
   );

   // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1.
   function automatic word_t rand_bits(input int n);
      word_t r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   task automatic check_value(input string name, input word_t got, input word_t want);
      checks++;
      if (got !== want) begin
         errors++;
         $display("[ERROR] %s: got %h, expected %h", name, got, want);
      end
   endtask

   task automatic end_test(input string name);
      $display("%s: %0d checks, %0d errors", name, checks - test_checks, errors - test_errors);
      test_checks = checks;
      test_errors = errors;
   endtask

   // One request through the DUT. With pile_on a second request is held on start
   // while the first one is in progress.
   task automatic access(input opcode_t op, input word_t a, input word_t wd,
                         input logic pile_on = 1'b0);
      int    b;
      int    size;
      int    n;
      logic  load;
      logic  err;
      logic  busy_ok;
      word_t want;
      b = int'(a % 1024);
      want = '0;
      load = (op == `EXE_LB || op == `EXE_LH || op == `EXE_LW ||
              op == `EXE_LBU || op == `EXE_LHU);
      case (op)
         `EXE_LW, `EXE_SW:           size = 4;
         `EXE_LH, `EXE_LHU, `EXE_SH: size = 2;
         `EXE_LB, `EXE_LBU, `EXE_SB: size = 1;
         default:                    size = 0;
      endcase
      err = (size > 0) && (b % size != 0);
      for (int k = 0; k < size && !err; k++) begin
         if (load)
            want[8*k +: 8] = model[b + k];
         else
            model[b + k] = wd[8*k +: 8];   // Low byte first.
      end
      if ((op == `EXE_LB || op == `EXE_LH) && !err && want[8*size-1])
         want = want | (~32'd0 << (8*size));
      @(posedge clk);
      start <= 1'b1;
      op_code <= op;
      addr <= a;
      write_data <= wd;
      @(posedge clk);
      if (pile_on) begin
         addr <= a ^ 32'd4;
         write_data <= ~wd;
         @(posedge clk);
      end
      start <= 1'b0;
      n = pile_on ? 1 : 0;
      busy_ok = 1'b1;
      @(negedge clk);
      while (!done && n < 20) begin
         busy_ok = busy_ok && busy;
         n++;
         @(negedge clk);
      end
      busy_ok = busy_ok && busy;
      if (!done)
         $display("Timeout: no done from the DUT within 20 cycles.");
      check_value("done latency", 32'(n), (size > 0 && !err) ? 32'd3 : 32'd1);
      check_value("read_data", read_data, want);
      check_value("addr_error_lw", 32'(addr_error_lw), 32'(err && load));
      check_value("addr_error_sw", 32'(addr_error_sw), 32'(err && !load));
      check_value("busy", 32'(busy_ok), 32'd1);
      @(negedge clk);
      check_value("busy", 32'(busy), 32'd0);   // Idle again one cycle after done.
   endtask

   initial begin
      word_t   a;
      word_t   wd;
      opcode_t op;
      int      n;
      int      sel;
      start = 1'b0;
      op_code = '0;
      addr = '0;
      write_data = '0;
      for (int i = 0; i < 1024; i++)
         model[i] = 8'h00;
      n = 0;
      while (!rst_n && n < 40) begin
         @(negedge clk);
         n++;
      end
      if (!rst_n) begin
         errors++;
         $display("Timeout: reset was never released.");
      end
      @(negedge clk);
      check_value("busy", 32'(busy), 32'd0);
      check_value("done", 32'(done), 32'd0);
      check_value("addr_error_lw", 32'(addr_error_lw), 32'd0);
      check_value("addr_error_sw", 32'(addr_error_sw), 32'd0);
      check_value("read_data", read_data, 32'd0);
      end_test("reset state");
      for (int i = 0; i < 16; i++) begin
         a = rand_bits(12) & ~32'd3;
         access(`EXE_SW, a, rand_bits(32));
         access(`EXE_LW, a, 32'd0);
      end
      end_test("word traffic");
      for (int i = 0; i < 8; i++) begin
         a = rand_bits(10) & ~32'd3;
         wd = rand_bits(32);
         access(`EXE_SB, a + rand_bits(2), wd);
         wd = rand_bits(32);
         access(`EXE_SH, a + 2 * rand_bits(1), wd);
         for (int k = 0; k < 4; k++) begin
            access(`EXE_LB, a + k, 32'd0);
            access(`EXE_LBU, a + k, 32'd0);
            if (k % 2 == 0) begin
               access(`EXE_LH, a + k, 32'd0);
               access(`EXE_LHU, a + k, 32'd0);
            end
         end
      end
      end_test("byte and halfword");
      for (int i = 0; i < 6; i++) begin
         a = rand_bits(10) & ~32'd3;
         access(`EXE_SW, a, rand_bits(32));
         access(`EXE_SW, a + 1 + rand_bits(2) % 3, 32'hdead_beef);
         access(`EXE_SH, a + 1 + 2 * rand_bits(1), 32'h0000_a5a5);
         access(`EXE_LW, a + 1 + rand_bits(2) % 3, 32'd0);
         access(`EXE_LH, a + 1, 32'd0);
         access(`EXE_LHU, a + 3, 32'd0);
         access(`EXE_LW, a, 32'd0);   // Word must be unchanged.
      end
      end_test("misaligned access");
      a = rand_bits(10) & ~32'd3;
      access(`EXE_SW, a, rand_bits(32), 1'b1);
      n = 0;
      for (int i = 0; i < 8; i++) begin
         @(negedge clk);
         if (done)
            n++;
      end
      check_value("extra done pulses", 32'(n), 32'd0);
      access(`EXE_LW, a, 32'd0);
      access(`EXE_LW, a ^ 32'd4, 32'd0);
      end_test("busy back-pressure");
      for (int i = 0; i < 200; i++) begin
         sel = int'(rand_bits(4));
         op = (sel < 8) ? op_table[sel] : opcode_t'(rand_bits(6));
         a = rand_bits(8);
         a = a | (rand_bits(2) << 10);   // Aliased upper bits make the RAM wrap.
         access(op, a, rand_bits(32));
      end
      end_test("random mix");
      n = dut0.master0.props0.assert_failures;
      $display("Summary: %0d checks, %0d errors, %0d assertion failures", checks, errors, n);
      if (errors == 0 && n == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

/* sim.f */
+incdir+verilog
verilog/lsu_pkg.sv
verilog/mem_control.sv
verilog/lsu_bus_master.sv
verilog/data_ram.sv
verilog/mem_stage.sv
testbench/tb_clock.sv
testbench/mem_stage_props.sv
testbench/mem_stage_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module mem_stage_tb -f sim.f
out=$(./obj_dir/Vmem_stage_tb +verilator+error+limit+1000 || true)
echo "$out"
echo "$out" | grep -qx "All tests passed!"
